//--- vlog.f
src/ds_pkg.sv
src/inst_decoder.sv
src/regfile.sv
src/operand_forward.sv
src/branch_unit.sv
src/id_stage.sv
verif/id_checker.sv
verif/tb_id_stage.sv

//--- run.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator
verilator --binary --timing -Wno-fatal --top-module tb_id_stage -f vlog.f -o sim_id_stage \
    && ./obj_dir/sim_id_stage | grep -q "STATUS: PASS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- verif/tb_id_stage.sv
module tb_id_stage;
    timeunit 1ns;
    timeprecision 1ps;

    localparam ds_pkg::word_t reset_pc = 32'h1bfffffc;
    localparam logic [4:0] r3_f5 [11] = '{5'h00, 5'h02, 5'h04, 5'h05, 5'h08, 5'h09,
                                          5'h0a, 5'h0b, 5'h0e, 5'h0f, 5'h10};
    localparam ds_pkg::alu_op_e r3_ops [11] = '{ds_pkg::alu_add, ds_pkg::alu_sub,
        ds_pkg::alu_slt, ds_pkg::alu_sltu, ds_pkg::alu_nor, ds_pkg::alu_and,
        ds_pkg::alu_or, ds_pkg::alu_xor, ds_pkg::alu_sll, ds_pkg::alu_srl, ds_pkg::alu_sra};
    localparam logic [3:0] ri_op4 [6] = '{4'h8, 4'h9, 4'ha, 4'hd, 4'he, 4'hf};
    localparam ds_pkg::alu_op_e ri_ops [6] = '{ds_pkg::alu_slt, ds_pkg::alu_sltu,
        ds_pkg::alu_add, ds_pkg::alu_and, ds_pkg::alu_or, ds_pkg::alu_xor};
    localparam logic [3:0] mem_op4 [8] = '{4'h0, 4'h1, 4'h2, 4'h4, 4'h5, 4'h6, 4'h8, 4'h9};
    localparam ds_pkg::mem_op_e mem_ops [8] = '{ds_pkg::ld_b, ds_pkg::ld_h, ds_pkg::ld_w,
        ds_pkg::st_b, ds_pkg::st_h, ds_pkg::st_w, ds_pkg::ld_bu, ds_pkg::ld_hu};

    logic              clk;
    logic              resetn;
    logic              fs_to_ds_valid;
    ds_pkg::word_t     fs_inst;
    ds_pkg::word_t     fs_pc;
    logic              ds_allowin;
    logic              es_allowin;
    logic              ds_to_es_valid;
    ds_pkg::ds_to_es_t ds_bundle;
    ds_pkg::fwd_src_t  es_fwd;
    ds_pkg::fwd_src_t  ms_fwd;
    ds_pkg::fwd_src_t  ws_fwd;
    logic              br_taken;
    ds_pkg::word_t     br_target;
    logic              br_stall;

    // model state
    integer            seed = 8;
    int                timeouts = 0;
    logic              chk_en;
    ds_pkg::word_t     shadow [32];
    logic              m_valid;
    ds_pkg::word_t     m_pc;
    ds_pkg::decode_t   cur;
    ds_pkg::decode_t   pend;
    ds_pkg::word_t     rj_v;
    ds_pkg::word_t     rk_v;
    logic              m_stall;
    logic              m_cond;
    logic              exp_valid;
    logic              exp_allowin;
    logic              exp_taken;
    logic              exp_br_stall;
    ds_pkg::word_t     exp_target;
    ds_pkg::ds_to_es_t exp_bundle;

    id_stage #(.RESET_PC(reset_pc)) i_dut (.*);

    id_checker i_check (
        .clk (clk), .en (chk_en),
        .dut_valid (ds_to_es_valid), .dut_allowin (ds_allowin), .dut_taken (br_taken),
        .dut_br_stall (br_stall), .dut_target (br_target), .dut_bundle (ds_bundle),
        .exp_valid (exp_valid), .exp_allowin (exp_allowin), .exp_taken (exp_taken),
        .exp_br_stall (exp_br_stall), .exp_target (exp_target), .exp_bundle (exp_bundle)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic ds_pkg::word_t rnd();
        return $random(seed);
    endfunction

    function automatic logic hit(input ds_pkg::fwd_src_t f, input ds_pkg::reg_addr_t ra);
        return f.we && ra != 5'd0 && f.waddr == ra;
    endfunction

    // ex, then mem, then wb, then the register file
    function automatic ds_pkg::word_t operand(input ds_pkg::reg_addr_t ra);
        if (ra == 5'd0) return '0;
        if (hit(es_fwd, ra)) return es_fwd.wdata;
        if (hit(ms_fwd, ra)) return ms_fwd.wdata;
        if (hit(ws_fwd, ra)) return ws_fwd.wdata;
        return shadow[ra];
    endfunction

    function automatic logic load_match(input ds_pkg::reg_addr_t ra);
        return (hit(es_fwd, ra) && es_fwd.res_from_mem)
            || (hit(ms_fwd, ra) && ms_fwd.res_from_mem);
    endfunction

    always_comb begin
        rj_v    = operand(cur.raddr1);
        rk_v    = operand(cur.raddr2);
        m_stall = m_valid && ((cur.need_r1 && load_match(cur.raddr1))
                           || (cur.need_r2 && load_match(cur.raddr2)));
        case (cur.br_op)
            ds_pkg::br_beq:  m_cond = rj_v == rk_v;
            ds_pkg::br_bne:  m_cond = rj_v != rk_v;
            ds_pkg::br_blt:  m_cond = $signed(rj_v) < $signed(rk_v);
            ds_pkg::br_bge:  m_cond = $signed(rj_v) >= $signed(rk_v);
            ds_pkg::br_bltu: m_cond = rj_v < rk_v;
            ds_pkg::br_bgeu: m_cond = rj_v >= rk_v;
            ds_pkg::br_none: m_cond = 1'b0;
            default:         m_cond = 1'b1;
        endcase
        exp_valid    = m_valid && !m_stall;
        exp_allowin  = !m_valid || (!m_stall && es_allowin);
        exp_taken    = exp_valid && m_cond;
        exp_br_stall = m_stall && cur.br_op != ds_pkg::br_none;
        exp_target   = ((cur.br_op == ds_pkg::br_jirl) ? rj_v : m_pc) + cur.br_offs;
        exp_bundle.pc        = m_pc;
        exp_bundle.alu_op    = cur.alu_op;
        exp_bundle.mem_op    = cur.mem_op;
        exp_bundle.alu_src1  = cur.src1_is_pc ? m_pc : rj_v;
        exp_bundle.alu_src2  = cur.src2_is_imm ? cur.imm : rk_v;
        exp_bundle.rkd_value = rk_v;
        exp_bundle.rf_we     = cur.rf_we && m_valid;
        exp_bundle.rf_waddr  = cur.dest;
    end

    always @(posedge clk) begin
        if (ws_fwd.we) begin
            shadow[ws_fwd.waddr] <= ws_fwd.wdata;
        end
        if (!resetn) begin
            m_valid <= 1'b0;
            m_pc    <= reset_pc;
            cur     <= '0;
        end else if (exp_allowin) begin
            m_valid <= fs_to_ds_valid && !exp_taken;
            if (fs_to_ds_valid) begin
                cur  <= pend;
                m_pc <= fs_pc;
            end
        end
    end

    // random instruction of one class, with its expected decode
    task automatic gen(input int cat, input logic [4:0] rmask,
                       output ds_pkg::word_t inst, output ds_pkg::decode_t d);
        ds_pkg::word_t t;
        ds_pkg::word_t u;
        int            k;
        logic          cond;
        logic          store;
        t = rnd();
        u = rnd();
        k = int'({1'b0, u[30:0]} % 11);
        d = '0;
        d.need_r1 = 1'b1;
        d.rf_we   = 1'b1;
        cond      = 1'b0;
        store     = 1'b0;
        case (cat)
            0: begin
                inst = {6'h00, 4'h0, 2'h1, r3_f5[k], t[14:10] & rmask, t[9:5] & rmask, t[4:0]};
                d.alu_op  = r3_ops[k];
                d.need_r2 = 1'b1;
            end
            1: begin
                k = k % 3;
                inst = {6'h00, 4'h1, 2'h0, 5'(8 * k + 1), t[14:10], t[9:5] & rmask, t[4:0]};
                d.alu_op = r3_ops[8 + k];
            end
            2: begin
                k = k % 6;
                inst = {6'h00, ri_op4[k], t[21:10], t[9:5] & rmask, t[4:0]};
                d.alu_op = ri_ops[k];
            end
            3, 4: begin
                inst = {(cat == 3) ? 6'h05 : 6'h07, 1'b0, t[24:5], t[4:0]};
                d.alu_op     = (cat == 3) ? ds_pkg::alu_lui : ds_pkg::alu_add;
                d.src1_is_pc = (cat == 4);
                d.need_r1    = 1'b0;
            end
            5: begin
                k = k % 8;
                inst = {6'h0a, mem_op4[k], t[21:10], t[9:5] & rmask, t[4:0] & rmask};
                d.mem_op = mem_ops[k];
                store    = k inside {3, 4, 5};
            end
            default: begin
                k = k % 9;
                inst = {6'(6'h13 + k), t[25:10], t[9:5] & rmask, t[4:0] & rmask};
                d.br_op = ds_pkg::br_op_e'((k == 0) ? 9 : k + ((k < 3) ? 6 : -2));
                cond    = k >= 3;
            end
        endcase
        d.raddr1 = inst[9:5];
        d.raddr2 = (cond || store) ? inst[4:0] : inst[14:10];
        d.dest   = (d.br_op == ds_pkg::br_bl) ? 5'd1 : inst[4:0];
        d.imm    = {{20{inst[21]}}, inst[21:10]};
        if (cat == 2 && k > 2) d.imm = {20'b0, inst[21:10]};
        if (cat == 3 || cat == 4) d.imm = {inst[24:5], 12'b0};
        d.br_offs     = {{14{inst[25]}}, inst[25:10], 2'b0};
        d.src2_is_imm = !(cat == 0 || cond || d.br_op == ds_pkg::br_b);
        d.need_r2     = d.need_r2 || cond || store;
        d.rf_we       = !(cond || store || d.br_op == ds_pkg::br_b);
        if (d.br_op == ds_pkg::br_b || d.br_op == ds_pkg::br_bl) begin
            d.br_offs = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0};
            d.need_r1 = 1'b0;
        end
        if (d.br_op == ds_pkg::br_bl || d.br_op == ds_pkg::br_jirl) begin
            d.src1_is_pc = 1'b1;
            d.imm        = 32'd4;
        end
    endtask

    function automatic ds_pkg::fwd_src_t rand_fwd(input logic [4:0] rmask, input logic load);
        ds_pkg::fwd_src_t f;
        ds_pkg::word_t    t;
        t = rnd();
        f.we           = t[0];
        f.waddr        = t[5:1] & rmask;
        f.wdata        = rnd();
        f.res_from_mem = load;
        return f;
    endfunction

    task automatic fetch_inst(input int cat, input logic [4:0] rmask);
        ds_pkg::word_t   inst;
        ds_pkg::decode_t d;
        ds_pkg::word_t   t;
        int              n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!ds_allowin && n < 50);
        if (!ds_allowin) begin
            $display("timeout waiting for ds_allowin at %0t", $time);
            timeouts++;
        end
        gen(cat, rmask, inst, d);
        t = rnd();
        fs_to_ds_valid = 1'b1;
        fs_inst        = inst;
        fs_pc          = {t[31:2], 2'b00};
        pend           = d;
        @(posedge clk);
    endtask

    task automatic drain();
        int n;
        for (n = 0; n < 50; n++) begin
            @(posedge clk);
            if (ds_to_es_valid && es_allowin) break;
        end
        if (n == 50) begin
            $display("timeout waiting for the bundle to leave at %0t", $time);
            timeouts++;
        end
        @(negedge clk);
    endtask

    initial begin
        resetn         = 1'b0;
        chk_en         = 1'b0;
        fs_to_ds_valid = 1'b0;
        fs_inst        = '0;
        fs_pc          = '0;
        es_allowin     = 1'b1;
        es_fwd         = '0;
        ms_fwd         = '0;
        ws_fwd         = '0;
        pend           = '0;
        for (int i = 0; i < 8; i++) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        chk_en = 1'b1;
        for (int i = 0; i < 4; i++) @(negedge clk);
        i_check.test_done("reset");

        // preload every register through the writeback port
        for (int r = 1; r < 32; r++) begin
            @(negedge clk);
            ws_fwd = '{we: 1'b1, waddr: 5'(r), wdata: rnd(), res_from_mem: 1'b0};
        end
        @(negedge clk);
        ws_fwd = '0;

        for (int i = 0; i < 40; i++) begin
            fetch_inst(int'({1'b0, rnd() & 31'h7fff} % 5), 5'h1f);
            @(negedge clk);
            fs_to_ds_valid = 1'b0;
            drain();
        end
        i_check.test_done("alu_decode");

        for (int i = 0; i < 30; i++) begin
            fetch_inst(5, 5'h1f);
            @(negedge clk);
            fs_to_ds_valid = 1'b0;
            drain();
        end
        i_check.test_done("load_store");

        for (int i = 0; i < 40; i++) begin
            fetch_inst((i % 3 == 2) ? 5 : i % 3, 5'h07);
            @(negedge clk);
            fs_to_ds_valid = 1'b0;
            es_fwd = rand_fwd(5'h07, 1'b0);
            ms_fwd = rand_fwd(5'h07, 1'b0);
            ws_fwd = rand_fwd(5'h07, 1'b0);
            drain();
        end
        i_check.test_done("forwarding");

        for (int i = 0; i < 20; i++) begin
            // branches in every other pair, so br_stall rises too
            fetch_inst(i[1] ? 6 : 0, 5'h07);
            @(negedge clk);
            fs_to_ds_valid = 1'b0;
            ws_fwd = '0;
            ms_fwd = '0;
            es_fwd = '{we: 1'b1, waddr: i[0] ? cur.raddr2 : cur.raddr1,
                       wdata: rnd(), res_from_mem: 1'b1};
            @(negedge clk);
            @(negedge clk);
            // load moves on to mem
            ms_fwd = es_fwd;
            es_fwd = '0;
            @(negedge clk);
            @(negedge clk);
            ms_fwd     = '0;
            es_allowin = 1'b0;
            @(negedge clk);
            @(negedge clk);
            es_allowin = 1'b1;
            // a load to r0 or to an unused source does not stall
            if (m_valid) drain();
        end
        i_check.test_done("load_use");

        for (int i = 0; i < 40; i++) begin
            fetch_inst(6, 5'h07);
            fetch_inst(2, 5'h1f);
            @(negedge clk);
            fs_to_ds_valid = 1'b0;
            es_fwd = rand_fwd(5'h07, 1'b0);
            if (m_valid) drain();
        end
        i_check.test_done("branch");

        @(negedge clk);
        chk_en = 1'b0;
        $display("tests %0d, failed %0d, mismatches %0d, timeouts %0d", i_check.tests_run,
                 i_check.tests_failed, i_check.errors, timeouts);
        if (i_check.errors == 0 && timeouts == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- verif/id_checker.sv
module id_checker (
    input  logic              clk,
    input  logic              en,
    input  logic              dut_valid,
    input  logic              dut_allowin,
    input  logic              dut_taken,
    input  logic              dut_br_stall,
    input  ds_pkg::word_t     dut_target,
    input  ds_pkg::ds_to_es_t dut_bundle,
    input  logic              exp_valid,
    input  logic              exp_allowin,
    input  logic              exp_taken,
    input  logic              exp_br_stall,
    input  ds_pkg::word_t     exp_target,
    input  ds_pkg::ds_to_es_t exp_bundle
);
    timeunit 1ns;
    timeprecision 1ps;

    int errors       = 0;
    int test_errors  = 0;
    int tests_run    = 0;
    int tests_failed = 0;

    task automatic compare(input string what, input ds_pkg::word_t got, input ds_pkg::word_t exp);
        if (got !== exp) begin
            $display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    always @(posedge clk) begin
        if (en) begin
            compare("ds_to_es_valid", 32'(dut_valid), 32'(exp_valid));
            compare("ds_allowin", 32'(dut_allowin), 32'(exp_allowin));
            compare("br_taken", 32'(dut_taken), 32'(exp_taken));
            compare("br_stall", 32'(dut_br_stall), 32'(exp_br_stall));
            // write enable must stay low in an empty stage
            compare("rf_we", 32'(dut_bundle.rf_we), 32'(exp_bundle.rf_we));
            if (exp_taken) begin
                compare("br_target", dut_target, exp_target);
            end
            // bundle only matters while it is offered to execute
            if (exp_valid) begin
                compare("pc", dut_bundle.pc, exp_bundle.pc);
                compare("alu_op", 32'(dut_bundle.alu_op), 32'(exp_bundle.alu_op));
                compare("mem_op", 32'(dut_bundle.mem_op), 32'(exp_bundle.mem_op));
                compare("alu_src1", dut_bundle.alu_src1, exp_bundle.alu_src1);
                compare("alu_src2", dut_bundle.alu_src2, exp_bundle.alu_src2);
                compare("rkd_value", dut_bundle.rkd_value, exp_bundle.rkd_value);
                compare("rf_waddr", 32'(dut_bundle.rf_waddr), 32'(exp_bundle.rf_waddr));
            end
        end
    end

    task automatic test_done(input string name);
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("test %s: %s, %0d mismatches", name,
                 (test_errors != 0) ? "failed" : "passed", test_errors);
        test_errors = 0;
    endtask

endmodule

//--- src/id_stage.sv
module id_stage #(
    parameter ds_pkg::word_t RESET_PC = 32'h1bfffffc
) (
    input  logic              clk,
    input  logic              resetn,

    // from fetch
    input  logic              fs_to_ds_valid,
    input  ds_pkg::word_t     fs_inst,
    input  ds_pkg::word_t     fs_pc,
    output logic              ds_allowin,

    // to execute
    input  logic              es_allowin,
    output logic              ds_to_es_valid,
    output ds_pkg::ds_to_es_t ds_bundle,

    // later stage writes
    input  ds_pkg::fwd_src_t  es_fwd,
    input  ds_pkg::fwd_src_t  ms_fwd,
    input  ds_pkg::fwd_src_t  ws_fwd,

    // to fetch
    output logic              br_taken,
    output ds_pkg::word_t     br_target,
    output logic              br_stall
);

    logic            ds_valid;
    logic            ds_ready_go;
    logic            fwd_stall;
    logic            ds_stall;
    ds_pkg::word_t   ds_inst;
    ds_pkg::word_t   ds_pc;
    ds_pkg::decode_t dec;
    ds_pkg::word_t   rf_rdata1;
    ds_pkg::word_t   rf_rdata2;
    ds_pkg::word_t   rj_value;
    ds_pkg::word_t   rkd_value;

    ////////////////////
    // handshake
    ////////////////////

    // stale instruction must not stall an empty stage
    assign ds_stall       = fwd_stall && ds_valid;
    assign ds_ready_go    = !ds_stall;
    assign ds_allowin     = !ds_valid || (ds_ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ds_ready_go;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            // taken branch kills the word fetch is presenting
            ds_valid <= fs_to_ds_valid && !br_taken;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ds_inst <= '0;
            ds_pc   <= RESET_PC;
        end else if (ds_allowin && fs_to_ds_valid) begin
            ds_inst <= fs_inst;
            ds_pc   <= fs_pc;
        end
    end

    ////////////////////
    // decode and operands
    ////////////////////

    inst_decoder u_decoder (
        .inst (ds_inst),
        .dec  (dec)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (dec.raddr1),
        .raddr2 (dec.raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .wr     (ws_fwd)
    );

    operand_forward u_forward (
        .dec       (dec),
        .rf_rdata1 (rf_rdata1),
        .rf_rdata2 (rf_rdata2),
        .es_fwd    (es_fwd),
        .ms_fwd    (ms_fwd),
        .ws_fwd    (ws_fwd),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .stall     (fwd_stall)
    );

    branch_unit u_branch (
        .br_op     (dec.br_op),
        .pc        (ds_pc),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .br_offs   (dec.br_offs),
        .valid     (ds_valid),
        .stall     (ds_stall),
        .br_taken  (br_taken),
        .br_target (br_target),
        .br_stall  (br_stall)
    );

    ////////////////////
    // bundle to execute
    ////////////////////

    always_comb begin
        ds_bundle.pc        = ds_pc;
        ds_bundle.alu_op    = dec.alu_op;
        ds_bundle.mem_op    = dec.mem_op;
        ds_bundle.alu_src1  = dec.src1_is_pc ? ds_pc : rj_value;
        ds_bundle.alu_src2  = dec.src2_is_imm ? dec.imm : rkd_value;
        ds_bundle.rkd_value = rkd_value;
        ds_bundle.rf_we     = dec.rf_we && ds_valid;
        ds_bundle.rf_waddr  = dec.dest;
    end

endmodule

//--- src/branch_unit.sv
module branch_unit (
    input  ds_pkg::br_op_e br_op,
    input  ds_pkg::word_t  pc,
    input  ds_pkg::word_t  rj_value,
    input  ds_pkg::word_t  rkd_value,
    input  ds_pkg::word_t  br_offs,
    input  logic           valid,
    input  logic           stall,
    output logic           br_taken,
    output ds_pkg::word_t  br_target,
    output logic           br_stall
);

    logic eq;
    logic lt;
    logic ltu;
    logic cond;

    assign eq  = (rj_value == rkd_value);
    assign lt  = ($signed(rj_value) < $signed(rkd_value));
    assign ltu = (rj_value < rkd_value);

    always_comb begin
        case (br_op)
            ds_pkg::br_beq:  cond = eq;
            ds_pkg::br_bne:  cond = !eq;
            ds_pkg::br_blt:  cond = lt;
            ds_pkg::br_bge:  cond = !lt;
            ds_pkg::br_bltu: cond = ltu;
            ds_pkg::br_bgeu: cond = !ltu;
            ds_pkg::br_b,
            ds_pkg::br_bl,
            ds_pkg::br_jirl: cond = 1'b1;
            default:         cond = 1'b0;
        endcase
    end

    // operands are only trusted once the stall clears
    assign br_taken  = valid && !stall && cond;
    assign br_target = (br_op == ds_pkg::br_jirl) ? rj_value + br_offs : pc + br_offs;
    assign br_stall  = stall && (br_op != ds_pkg::br_none);

endmodule

//--- src/operand_forward.sv
module operand_forward (
    input  ds_pkg::decode_t  dec,
    input  ds_pkg::word_t    rf_rdata1,
    input  ds_pkg::word_t    rf_rdata2,
    input  ds_pkg::fwd_src_t es_fwd,
    input  ds_pkg::fwd_src_t ms_fwd,
    input  ds_pkg::fwd_src_t ws_fwd,
    output ds_pkg::word_t    rj_value,
    output ds_pkg::word_t    rkd_value,
    output logic             stall
);

    function automatic logic hits(input ds_pkg::fwd_src_t f, input ds_pkg::reg_addr_t ra);
        return f.we && (ra != '0) && (f.waddr == ra);
    endfunction

    // youngest write wins
    function automatic ds_pkg::word_t pick_operand(input ds_pkg::reg_addr_t ra,
                                                   input ds_pkg::word_t rf_val);
        if (hits(es_fwd, ra)) begin
            return es_fwd.wdata;
        end else if (hits(ms_fwd, ra)) begin
            return ms_fwd.wdata;
        end else if (hits(ws_fwd, ra)) begin
            return ws_fwd.wdata;
        end
        return rf_val;
    endfunction

    // load data not back yet in ex or mem
    function automatic logic load_pending(input ds_pkg::reg_addr_t ra);
        return (hits(es_fwd, ra) && es_fwd.res_from_mem)
            || (hits(ms_fwd, ra) && ms_fwd.res_from_mem);
    endfunction

    always_comb begin
        rj_value  = pick_operand(dec.raddr1, rf_rdata1);
        rkd_value = pick_operand(dec.raddr2, rf_rdata2);
        stall     = (dec.need_r1 && load_pending(dec.raddr1))
                 || (dec.need_r2 && load_pending(dec.raddr2));
    end

endmodule

//--- src/regfile.sv
module regfile (
    input  logic              clk,
    input  ds_pkg::reg_addr_t raddr1,
    input  ds_pkg::reg_addr_t raddr2,
    output ds_pkg::word_t     rdata1,
    output ds_pkg::word_t     rdata2,
    input  ds_pkg::fwd_src_t  wr
);

    ds_pkg::word_t rf [2**ds_pkg::reg_addr_w];

    always_ff @(posedge clk) begin
        if (wr.we) begin
            rf[wr.waddr] <= wr.wdata;
        end
    end

    // r0 is hardwired zero
    assign rdata1 = (raddr1 == '0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : rf[raddr2];

endmodule

//--- src/inst_decoder.sv
module inst_decoder (
    input  ds_pkg::word_t   inst,
    output ds_pkg::decode_t dec
);

    logic [5:0]        op_31_26;
    logic [3:0]        op_25_22;
    logic [1:0]        op_21_20;
    logic [4:0]        op_19_15;
    ds_pkg::reg_addr_t rd;
    ds_pkg::reg_addr_t rj;
    ds_pkg::reg_addr_t rk;
    logic [11:0]       i12;
    logic [19:0]       i20;
    logic [15:0]       i16;
    logic [25:0]       i26;

    ds_pkg::alu_op_e   alu_op;
    ds_pkg::mem_op_e   mem_op;
    ds_pkg::br_op_e    br_op;
    logic              known;
    logic              use_rk;
    logic              imm_si12;
    logic              is_lui;
    logic              is_pcadd;
    logic              cond_br;
    logic              store;
    logic              uncond_b;
    logic              link;

    assign op_31_26 = inst[31:26];
    assign op_25_22 = inst[25:22];
    assign op_21_20 = inst[21:20];
    assign op_19_15 = inst[19:15];

    assign rd  = inst[4:0];
    assign rj  = inst[9:5];
    assign rk  = inst[14:10];
    assign i12 = inst[21:10];
    assign i20 = inst[24:5];
    assign i16 = inst[25:10];
    assign i26 = {inst[9:0], inst[25:10]};

    assign is_lui   = (op_31_26 == 6'h05) && !inst[25];
    assign is_pcadd = (op_31_26 == 6'h07) && !inst[25];

    ////////////////////
    // opcode match
    ////////////////////

    always_comb begin
        alu_op   = ds_pkg::alu_add;
        mem_op   = ds_pkg::mem_none;
        br_op    = ds_pkg::br_none;
        known    = 1'b0;
        use_rk   = 1'b0;
        imm_si12 = 1'b0;
        case (op_31_26)
            6'h00: begin
                if (op_25_22 == 4'h0 && op_21_20 == 2'h1) begin
                    // three-register alu
                    known  = 1'b1;
                    use_rk = 1'b1;
                    case (op_19_15)
                        5'h00: alu_op = ds_pkg::alu_add;
                        5'h02: alu_op = ds_pkg::alu_sub;
                        5'h04: alu_op = ds_pkg::alu_slt;
                        5'h05: alu_op = ds_pkg::alu_sltu;
                        5'h08: alu_op = ds_pkg::alu_nor;
                        5'h09: alu_op = ds_pkg::alu_and;
                        5'h0a: alu_op = ds_pkg::alu_or;
                        5'h0b: alu_op = ds_pkg::alu_xor;
                        5'h0e: alu_op = ds_pkg::alu_sll;
                        5'h0f: alu_op = ds_pkg::alu_srl;
                        5'h10: alu_op = ds_pkg::alu_sra;
                        default: begin
                            known  = 1'b0;
                            use_rk = 1'b0;
                        end
                    endcase
                end else if (op_25_22 == 4'h1 && op_21_20 == 2'h0) begin
                    // shift by ui5, low bits of si12
                    known    = 1'b1;
                    imm_si12 = 1'b1;
                    case (op_19_15)
                        5'h01: alu_op = ds_pkg::alu_sll;
                        5'h09: alu_op = ds_pkg::alu_srl;
                        5'h11: alu_op = ds_pkg::alu_sra;
                        default: known = 1'b0;
                    endcase
                end else begin
                    known = 1'b1;
                    case (op_25_22)
                        4'h8: alu_op = ds_pkg::alu_slt;
                        4'h9: alu_op = ds_pkg::alu_sltu;
                        4'ha: alu_op = ds_pkg::alu_add;
                        4'hd: alu_op = ds_pkg::alu_and;
                        4'he: alu_op = ds_pkg::alu_or;
                        4'hf: alu_op = ds_pkg::alu_xor;
                        default: known = 1'b0;
                    endcase
                    imm_si12 = known && (op_25_22 inside {4'h8, 4'h9, 4'ha});
                end
            end
            6'h05: begin
                known  = is_lui;
                alu_op = ds_pkg::alu_lui;
            end
            6'h07: known = is_pcadd;
            6'h0a: begin
                known    = 1'b1;
                imm_si12 = 1'b1;
                case (op_25_22)
                    4'h0: mem_op = ds_pkg::ld_b;
                    4'h1: mem_op = ds_pkg::ld_h;
                    4'h2: mem_op = ds_pkg::ld_w;
                    4'h4: mem_op = ds_pkg::st_b;
                    4'h5: mem_op = ds_pkg::st_h;
                    4'h6: mem_op = ds_pkg::st_w;
                    4'h8: mem_op = ds_pkg::ld_bu;
                    4'h9: mem_op = ds_pkg::ld_hu;
                    default: begin
                        known    = 1'b0;
                        imm_si12 = 1'b0;
                    end
                endcase
            end
            6'h13: br_op = ds_pkg::br_jirl;
            6'h14: br_op = ds_pkg::br_b;
            6'h15: br_op = ds_pkg::br_bl;
            6'h16: br_op = ds_pkg::br_beq;
            6'h17: br_op = ds_pkg::br_bne;
            6'h18: br_op = ds_pkg::br_blt;
            6'h19: br_op = ds_pkg::br_bge;
            6'h1a: br_op = ds_pkg::br_bltu;
            6'h1b: br_op = ds_pkg::br_bgeu;
            default: known = 1'b0;
        endcase
        if (br_op != ds_pkg::br_none) begin
            known = 1'b1;
        end
    end

    assign cond_br  = br_op inside {ds_pkg::br_beq, ds_pkg::br_bne, ds_pkg::br_blt,
                                    ds_pkg::br_bge, ds_pkg::br_bltu, ds_pkg::br_bgeu};
    assign store    = mem_op inside {ds_pkg::st_b, ds_pkg::st_h, ds_pkg::st_w};
    assign uncond_b = (br_op == ds_pkg::br_b);
    // jirl and bl write pc + 4
    assign link     = (br_op == ds_pkg::br_jirl) || (br_op == ds_pkg::br_bl);

    assign dec.alu_op      = alu_op;
    assign dec.mem_op      = mem_op;
    assign dec.br_op       = br_op;
    assign dec.src1_is_pc  = link || is_pcadd;
    assign dec.src2_is_imm = known && !use_rk && !cond_br && !uncond_b;
    assign dec.need_r1     = known && !is_lui && !is_pcadd && !uncond_b
                             && (br_op != ds_pkg::br_bl);
    assign dec.need_r2     = use_rk || cond_br || store;
    assign dec.rf_we       = known && !store && !cond_br && !uncond_b;
    assign dec.raddr1      = rj;
    assign dec.raddr2      = (cond_br || store) ? rd : rk;
    assign dec.dest        = (br_op == ds_pkg::br_bl) ? 5'd1 : rd;

    assign dec.imm = link                 ? 32'd4 :
                     (is_lui || is_pcadd) ? {i20, 12'b0} :
                     imm_si12             ? {{20{i12[11]}}, i12} :
                                            {20'b0, i12};

    assign dec.br_offs = (uncond_b || br_op == ds_pkg::br_bl) ? {{4{i26[25]}}, i26, 2'b0} :
                                                                {{14{i16[15]}}, i16, 2'b0};

endmodule

//--- src/ds_pkg.sv
package ds_pkg;

    parameter int xlen       = 32;
    parameter int reg_addr_w = 5;

    typedef logic [reg_addr_w-1:0] reg_addr_t;
    typedef logic [xlen-1:0]       word_t;

    ////////////////////
    // opcodes
    ////////////////////

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_nor,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui
    } alu_op_e;

    typedef enum logic [3:0] {
        mem_none,
        ld_b,
        ld_bu,
        ld_h,
        ld_hu,
        ld_w,
        st_b,
        st_h,
        st_w
    } mem_op_e;

    typedef enum logic [3:0] {
        br_none,
        br_beq,
        br_bne,
        br_blt,
        br_bge,
        br_bltu,
        br_bgeu,
        br_b,
        br_bl,
        br_jirl
    } br_op_e;

    ////////////////////
    // bundles
    ////////////////////

    typedef struct packed {
        alu_op_e   alu_op;
        mem_op_e   mem_op;
        br_op_e    br_op;
        logic      src1_is_pc;
        logic      src2_is_imm;
        logic      need_r1;
        logic      need_r2;
        logic      rf_we;
        reg_addr_t raddr1;
        reg_addr_t raddr2;
        reg_addr_t dest;
        word_t     imm;
        word_t     br_offs;
    } decode_t;

    // one write from a later stage
    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
        logic      res_from_mem;
    } fwd_src_t;

    typedef struct packed {
        word_t     pc;
        alu_op_e   alu_op;
        mem_op_e   mem_op;
        word_t     alu_src1;
        word_t     alu_src2;
        word_t     rkd_value;
        logic      rf_we;
        reg_addr_t rf_waddr;
    } ds_to_es_t;

endpackage
